//--- hw/pbuf_defines.svh
`ifndef PBUF_DEFINES_SVH
`define PBUF_DEFINES_SVH

////////////////////////////////////////////////////////////
// buffer geometry
////////////////////////////////////////////////////////////

`define PBUF_DATA_W     64
`define PBUF_KEEP_W     (`PBUF_DATA_W / 8)  // one bit per data byte
`define PBUF_META_W     32
`define PBUF_ADDR_W     8
`define PBUF_DEPTH      256

////////////////////////////////////////////////////////////
// latencies
////////////////////////////////////////////////////////////

`define PBUF_DP_OUT_REG 1                   // second register on port b
`define PBUF_CPU_LAT    2                   // port a access to cpu result

`endif

//--- hw/pbuf_pkg.sv
`include "pbuf_defines.svh"

package pbuf_pkg;

    typedef logic [`PBUF_ADDR_W-1:0] addr_t;
    typedef logic [`PBUF_DATA_W-1:0] data_t;
    typedef logic [`PBUF_KEEP_W-1:0] keep_t;
    typedef logic [`PBUF_META_W-1:0] meta_t;

    // one packet memory word
    typedef struct packed {
        logic  last;
        keep_t keep;
        data_t data;
    } pkt_entry_t;

    typedef struct packed {
        logic       en;    // level, writes every cycle while high
        addr_t      addr;
        pkt_entry_t entry;
        meta_t      meta;
    } dp_write_t;

    typedef struct packed {
        pkt_entry_t entry;
        meta_t      meta;
    } dp_read_t;

    typedef struct packed {
        logic       rd;
        logic       wr;
        addr_t      addr;
        pkt_entry_t data;
    } cpu_pkt_req_t;

    typedef struct packed {
        logic  rd;
        logic  wr;
        addr_t addr;
        meta_t data;
    } cpu_meta_req_t;

    typedef struct packed {
        logic rd_pkt;
        logic wr_pkt;
        logic rd_meta;
        logic wr_meta;
    } cpu_access_t;

    typedef struct packed {
        logic       rd_pkt;
        logic       wr_pkt;
        logic       rd_meta;
        logic       wr_meta;
        pkt_entry_t pkt_data;
        meta_t      meta_data;
    } cpu_result_t;

    // port a of each memory
    typedef struct packed {
        logic       we;
        addr_t      addr;
        pkt_entry_t din;
    } pkt_ram_req_t;

    typedef struct packed {
        logic  we;
        addr_t addr;
        meta_t din;
    } meta_ram_req_t;

    typedef enum logic {
        ARB_IDLE    = 1'b0,
        ARB_WAIT_DP = 1'b1  // cpu request parked behind a dp write
    } arb_state_e;

endpackage

//--- hw/dual_port_ram.sv
module dual_port_ram #(
    parameter int WIDTH   = 32,
    parameter int DEPTH   = 256,
    parameter int OUT_REG = 1
) (
    input  logic              clk,
    input  logic              we_a,
    input  pbuf_pkg::addr_t   addr_a,
    input  logic [WIDTH-1:0]  din_a,
    output logic [WIDTH-1:0]  dout_a,
    input  pbuf_pkg::addr_t   addr_b,
    output logic [WIDTH-1:0]  dout_b
);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [WIDTH-1:0] rd_b;

    // port a, read before write
    always_ff @(posedge clk)
    begin
        if (we_a)
        begin
            mem[addr_a] <= din_a;
        end
        dout_a <= mem[addr_a];
    end

    // port b is read only
    always_ff @(posedge clk)
    begin
        rd_b <= mem[addr_b];
    end

    generate
        if (OUT_REG != 0)
        begin : g_out_reg
            always_ff @(posedge clk)
            begin
                dout_b <= rd_b;
            end
        end
        else
        begin : g_no_out_reg
            assign dout_b = rd_b;
        end
    endgenerate

endmodule

//--- hw/cpu_port_arbiter.sv
module cpu_port_arbiter (
    input  logic                    clk,
    input  logic                    rstn,
    input  pbuf_pkg::dp_write_t     dp_wr,
    input  pbuf_pkg::cpu_pkt_req_t  cpu_pkt,
    input  pbuf_pkg::cpu_meta_req_t cpu_meta,
    output pbuf_pkg::pkt_ram_req_t  pkt_a,
    output pbuf_pkg::meta_ram_req_t meta_a,
    output pbuf_pkg::cpu_access_t   cpu_access
);

    import pbuf_pkg::*;

    arb_state_e    state;
    arb_state_e    state_next;

    cpu_access_t   req;            // raw cpu strobes
    logic          req_valid;
    logic          req_is_meta;
    pkt_ram_req_t  cpu_pkt_req;
    meta_ram_req_t cpu_meta_req;
    logic          park;

    // parked request
    logic          pend_is_meta;
    pkt_ram_req_t  pend_pkt_req;
    meta_ram_req_t pend_meta_req;

    ////////////////////////////////////////////////////////////
    // request decode
    ////////////////////////////////////////////////////////////

    assign req         = {cpu_pkt.rd, cpu_pkt.wr, cpu_meta.rd, cpu_meta.wr};
    assign req_valid   = $onehot(req);  // two or more strobes do nothing
    assign req_is_meta = cpu_meta.rd | cpu_meta.wr;

    assign cpu_pkt_req  = '{we: cpu_pkt.wr, addr: cpu_pkt.addr, din: cpu_pkt.data};
    assign cpu_meta_req = '{we: cpu_meta.wr, addr: cpu_meta.addr, din: cpu_meta.data};

    ////////////////////////////////////////////////////////////
    // port a mux
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        // dataplane write owns port a by default
        pkt_a      = '{we: dp_wr.en, addr: dp_wr.addr, din: dp_wr.entry};
        meta_a     = '{we: dp_wr.en, addr: dp_wr.addr, din: dp_wr.meta};
        cpu_access = '0;
        state_next = state;
        park       = 1'b0;

        case (state)
            ARB_IDLE:
            begin
                if (req_valid)
                begin
                    if (dp_wr.en)
                    begin
                        park       = 1'b1;
                        state_next = ARB_WAIT_DP;
                    end
                    else
                    begin
                        // apply at once on a free port
                        if (req_is_meta)
                        begin
                            meta_a = cpu_meta_req;
                        end
                        else
                        begin
                            pkt_a = cpu_pkt_req;
                        end
                        cpu_access = req;
                    end
                end
            end

            ARB_WAIT_DP:
            begin
                // new strobes ignored here
                if (!dp_wr.en)
                begin
                    state_next = ARB_IDLE;
                    if (pend_is_meta)
                    begin
                        meta_a             = pend_meta_req;
                        cpu_access.rd_meta = ~pend_meta_req.we;
                        cpu_access.wr_meta = pend_meta_req.we;
                    end
                    else
                    begin
                        pkt_a             = pend_pkt_req;
                        cpu_access.rd_pkt = ~pend_pkt_req.we;
                        cpu_access.wr_pkt = pend_pkt_req.we;
                    end
                end
            end

            default:
            begin
                state_next = ARB_IDLE;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // state and pending register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            state <= ARB_IDLE;
        end
        else
        begin
            state <= state_next;
        end
    end

    // capture on park
    always_ff @(posedge clk)
    begin
        if (park)
        begin
            pend_is_meta  <= req_is_meta;
            pend_pkt_req  <= cpu_pkt_req;
            pend_meta_req <= cpu_meta_req;
        end
    end

endmodule

//--- hw/cpu_response.sv
module cpu_response (
    input  logic                  clk,
    input  logic                  rstn,
    input  pbuf_pkg::cpu_access_t cpu_access,
    input  pbuf_pkg::pkt_entry_t  pkt_douta,
    input  pbuf_pkg::meta_t       meta_douta,
    output pbuf_pkg::cpu_result_t cpu_res
);

    import pbuf_pkg::*;

    cpu_access_t acc_d1;
    cpu_access_t acc_d2;
    pkt_entry_t  pkt_rd_q;
    meta_t       meta_rd_q;

    // strobe delay, one edge for the ram read and one here
    always_ff @(posedge clk)
    begin
        if (!rstn)
        begin
            acc_d1 <= '0;
            acc_d2 <= '0;
        end
        else
        begin
            acc_d1 <= cpu_access;
            acc_d2 <= acc_d1;
        end
    end

    // port a read data, aligned with acc_d2
    always_ff @(posedge clk)
    begin
        pkt_rd_q  <= pkt_douta;
        meta_rd_q <= meta_douta;
    end

    always_comb
    begin
        cpu_res.rd_pkt    = acc_d2.rd_pkt;
        cpu_res.wr_pkt    = acc_d2.wr_pkt;
        cpu_res.rd_meta   = acc_d2.rd_meta;
        cpu_res.wr_meta   = acc_d2.wr_meta;
        cpu_res.pkt_data  = pkt_rd_q;
        cpu_res.meta_data = meta_rd_q;
    end

endmodule

//--- hw/pkt_buffer_top.sv
`include "pbuf_defines.svh"

module pkt_buffer_top (
    input  logic                    clk,
    input  logic                    rstn,
    input  pbuf_pkg::dp_write_t     dp_wr,
    input  pbuf_pkg::addr_t         dp_rd_addr,
    input  pbuf_pkg::cpu_pkt_req_t  cpu_pkt,
    input  pbuf_pkg::cpu_meta_req_t cpu_meta,
    output pbuf_pkg::dp_read_t      dp_rd,
    output pbuf_pkg::cpu_result_t   cpu_res
);

    import pbuf_pkg::*;

    pkt_ram_req_t  pkt_a;
    meta_ram_req_t meta_a;
    cpu_access_t   cpu_access;

    pkt_entry_t    pkt_douta;
    pkt_entry_t    pkt_doutb;
    meta_t         meta_douta;
    meta_t         meta_doutb;

    ////////////////////////////////////////////////////////////
    // port a arbitration
    ////////////////////////////////////////////////////////////

    cpu_port_arbiter arb_i (
        .clk        (clk),
        .rstn       (rstn),
        .dp_wr      (dp_wr),
        .cpu_pkt    (cpu_pkt),
        .cpu_meta   (cpu_meta),
        .pkt_a      (pkt_a),
        .meta_a     (meta_a),
        .cpu_access (cpu_access)
    );

    ////////////////////////////////////////////////////////////
    // memories, port b shared by the dataplane read
    ////////////////////////////////////////////////////////////

    dual_port_ram #(
        .WIDTH   ($bits(pkt_entry_t)),
        .DEPTH   (`PBUF_DEPTH),
        .OUT_REG (`PBUF_DP_OUT_REG)
    ) pkt_ram_i (
        .clk    (clk),
        .we_a   (pkt_a.we),
        .addr_a (pkt_a.addr),
        .din_a  (pkt_a.din),
        .dout_a (pkt_douta),
        .addr_b (dp_rd_addr),
        .dout_b (pkt_doutb)
    );

    dual_port_ram #(
        .WIDTH   ($bits(meta_t)),
        .DEPTH   (`PBUF_DEPTH),
        .OUT_REG (`PBUF_DP_OUT_REG)
    ) meta_ram_i (
        .clk    (clk),
        .we_a   (meta_a.we),
        .addr_a (meta_a.addr),
        .din_a  (meta_a.din),
        .dout_a (meta_douta),
        .addr_b (dp_rd_addr),
        .dout_b (meta_doutb)
    );

    assign dp_rd = '{entry: pkt_doutb, meta: meta_doutb};

    cpu_response resp_i (
        .clk        (clk),
        .rstn       (rstn),
        .cpu_access (cpu_access),
        .pkt_douta  (pkt_douta),
        .meta_douta (meta_douta),
        .cpu_res    (cpu_res)
    );

endmodule

//--- tests/pkt_buffer_props.sv
module pkt_buffer_props (
    input logic                  clk,
    input logic                  rstn,
    input pbuf_pkg::dp_write_t   dp_wr,
    input pbuf_pkg::cpu_access_t cpu_access,
    input pbuf_pkg::arb_state_e  state
);

    import pbuf_pkg::*;

    logic [3:0] acc_bits;

    assign acc_bits = cpu_access;

    // one memory per port a cycle
    a_single_access: assert property (@(posedge clk) disable iff (!rstn)
        $onehot0(acc_bits))
    else $error("more than one cpu access strobe in a cycle");

    a_dp_owns_port: assert property (@(posedge clk) disable iff (!rstn)
        dp_wr.en |-> (acc_bits == 4'b0000))
    else $error("cpu access while a dataplane write holds port a");

    a_replay_done: assert property (@(posedge clk) disable iff (!rstn)
        (state == ARB_WAIT_DP && !dp_wr.en) |=> (state == ARB_IDLE))
    else $error("parked request not replayed when write enable dropped");

endmodule

bind cpu_port_arbiter pkt_buffer_props props_i (
    .clk        (clk),
    .rstn       (rstn),
    .dp_wr      (dp_wr),
    .cpu_access (cpu_access),
    .state      (state)
);

//--- tests/pkt_buffer_tb.sv
`include "pbuf_defines.svh"

module pkt_buffer_tb;

    import pbuf_pkg::*;

    localparam int TEST_CYCLES    = 500;              // rough length of all tests
    localparam int TIMEOUT_CYCLES = 4 * TEST_CYCLES;
    localparam int RESULT_WAIT    = `PBUF_CPU_LAT + 4;

    // strobe order as in cpu_res
    localparam logic [3:0] STB_RD_PKT  = 4'b1000;
    localparam logic [3:0] STB_WR_PKT  = 4'b0100;
    localparam logic [3:0] STB_RD_META = 4'b0010;
    localparam logic [3:0] STB_WR_META = 4'b0001;

    logic          clk;
    logic          rstn;
    dp_write_t     dp_wr;
    addr_t         dp_rd_addr;
    cpu_pkt_req_t  cpu_pkt;
    cpu_meta_req_t cpu_meta;
    dp_read_t      dp_rd;
    cpu_result_t   cpu_res;

    pkt_entry_t    pkt_model [addr_t];
    meta_t         meta_model [addr_t];
    int            cycle_count = 0;

    pkt_buffer_top dut_i (
        .clk        (clk),
        .rstn       (rstn),
        .dp_wr      (dp_wr),
        .dp_rd_addr (dp_rd_addr),
        .cpu_pkt    (cpu_pkt),
        .cpu_meta   (cpu_meta),
        .dp_rd      (dp_rd),
        .cpu_res    (cpu_res)
    );

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            fail_now($sformatf("run did not finish within %0d cycles", TIMEOUT_CYCLES));
        end
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (actual !== expected)
        begin
            fail_now($sformatf("FAIL %s: expected %0h, actual %0h", name, expected, actual));
        end
    endtask

    function automatic logic [3:0] strobes();
        return {cpu_res.rd_pkt, cpu_res.wr_pkt, cpu_res.rd_meta, cpu_res.wr_meta};
    endfunction

    function automatic pkt_entry_t rand_entry();
        pkt_entry_t e;
        e.data = {$urandom, $urandom};
        e.keep = keep_t'($urandom);
        e.last = 1'($urandom);
        return e;
    endfunction

    task automatic clear_cpu();
        cpu_pkt  = '0;
        cpu_meta = '0;
    endtask

    task automatic cpu_pkt_access(input logic wr, input addr_t addr, input pkt_entry_t data);
        @(negedge clk);
        cpu_pkt = '{rd: ~wr, wr: wr, addr: addr, data: data};
    endtask

    task automatic cpu_meta_access(input logic wr, input addr_t addr, input meta_t data);
        @(negedge clk);
        cpu_meta = '{rd: ~wr, wr: wr, addr: addr, data: data};
    endtask

    // one dp write cycle, no result strobe may show meanwhile
    task automatic dp_write_cycle(input string name, input addr_t addr);
        pkt_entry_t entry;
        meta_t      meta;
        entry = rand_entry();
        meta  = $urandom;
        @(negedge clk);
        check_value({name, " early strobe"}, 128'(0), 128'(strobes()));
        clear_cpu();
        dp_wr = '{en: 1'b1, addr: addr, entry: entry, meta: meta};
        pkt_model[addr]  = entry;
        meta_model[addr] = meta;
    endtask

    task automatic dp_release();
        @(negedge clk);
        dp_wr = '0;
        clear_cpu();
    endtask

    // counts edges from the port a cycle to the strobe
    task automatic wait_result(input string name, input logic [3:0] expected);
        int         n;
        logic [3:0] seen;
        n    = 0;
        seen = '0;
        while (seen == '0 && n < RESULT_WAIT)
        begin
            @(negedge clk);
            clear_cpu();
            n++;
            seen = strobes();
        end
        if (seen == '0)
        begin
            fail_now($sformatf("%s: no result strobe within %0d cycles", name, RESULT_WAIT));
        end
        check_value({name, " latency"}, 128'(`PBUF_CPU_LAT), 128'(n));
        check_value({name, " strobe"}, 128'(expected), 128'(seen));
    endtask

    task automatic expect_no_strobe(input string name, input int cycles);
        for (int i = 0; i < cycles; i++)
        begin
            @(negedge clk);
            clear_cpu();
            check_value({name, " extra strobe"}, 128'(0), 128'(strobes()));
        end
    endtask

    task automatic check_dp_word(input string name, input addr_t addr);
        if (pkt_model.exists(addr))
        begin
            check_value($sformatf("%s entry @%0h", name, addr),
                        128'(pkt_model[addr]), 128'(dp_rd.entry));
        end
        if (meta_model.exists(addr))
        begin
            check_value($sformatf("%s meta @%0h", name, addr),
                        128'(meta_model[addr]), 128'(dp_rd.meta));
        end
    endtask

    // pipelined, result two edges after each address
    task automatic dp_read_check(input string name, input addr_t addrs[$]);
        int n;
        n = addrs.size();
        for (int i = 0; i < n + 2; i++)
        begin
            @(negedge clk);
            if (i >= 2)
            begin
                check_dp_word(name, addrs[i-2]);
            end
            if (i < n)
            begin
                dp_rd_addr = addrs[i];
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////

    task automatic test_reset_state();
        expect_no_strobe("reset", 10);
    endtask

    task automatic test_dp_write_read();
        addr_t addrs[$];
        for (int i = 0; i < 16; i++)
        begin
            dp_write_cycle("dp write", addr_t'(8'h10 + i));
            addrs.push_back(addr_t'(8'h10 + i));
        end
        dp_release();
        dp_read_check("dp read", addrs);
    endtask

    task automatic test_cpu_port_free();
        addr_t      a;
        pkt_entry_t e;
        meta_t      m;
        addr_t      addrs[$];
        a = 8'h40;
        e = rand_entry();
        m = $urandom;
        cpu_pkt_access(1'b1, a, e);
        pkt_model[a] = e;
        wait_result("cpu wr pkt", STB_WR_PKT);
        expect_no_strobe("cpu wr pkt", 1);
        cpu_meta_access(1'b1, a, m);
        meta_model[a] = m;
        wait_result("cpu wr meta", STB_WR_META);
        expect_no_strobe("cpu wr meta", 1);
        cpu_pkt_access(1'b0, a, '0);
        wait_result("cpu rd pkt", STB_RD_PKT);
        check_value("cpu rd pkt data", 128'(pkt_model[a]), 128'(cpu_res.pkt_data));
        expect_no_strobe("cpu rd pkt", 1);
        cpu_meta_access(1'b0, a, '0);
        wait_result("cpu rd meta", STB_RD_META);
        check_value("cpu rd meta data", 128'(meta_model[a]), 128'(cpu_res.meta_data));
        expect_no_strobe("cpu rd meta", 1);
        addrs.push_back(a);
        dp_read_check("cpu port free dp", addrs);
    endtask

    task automatic test_back_pressure();
        addr_t      a;
        pkt_entry_t e;
        int         len;
        addr_t      addrs[$];
        a   = 8'h50;
        e   = rand_entry();
        len = 6 + int'($urandom % 5);
        for (int i = 0; i < len; i++)
        begin
            dp_write_cycle("bp burst 1", addr_t'(8'h60 + i));
            addrs.push_back(addr_t'(8'h60 + i));
            if (i == len / 2)
            begin
                cpu_pkt = '{rd: 1'b0, wr: 1'b1, addr: a, data: e};  // parked
            end
        end
        pkt_model[a] = e;
        dp_release();
        wait_result("bp cpu wr", STB_WR_PKT);
        expect_no_strobe("bp cpu wr", 1);

        len = 6 + int'($urandom % 5);
        for (int i = 0; i < len; i++)
        begin
            dp_write_cycle("bp burst 2", addr_t'(8'h70 + i));
            addrs.push_back(addr_t'(8'h70 + i));
            if (i == len / 2)
            begin
                cpu_pkt = '{rd: 1'b1, wr: 1'b0, addr: a, data: '0};
            end
        end
        dp_release();
        wait_result("bp cpu rd", STB_RD_PKT);
        check_value("bp cpu rd data", 128'(pkt_model[a]), 128'(cpu_res.pkt_data));
        expect_no_strobe("bp cpu rd", 1);
        addrs.push_back(a);
        dp_read_check("bp dp", addrs);
    endtask

    task automatic test_ignored_requests();
        pkt_entry_t e;
        meta_t      m;
        addr_t      addrs[$];
        e = rand_entry();
        m = $urandom;
        // two memories in one cycle
        @(negedge clk);
        cpu_pkt  = '{rd: 1'b0, wr: 1'b1, addr: 8'h40, data: e};
        cpu_meta = '{rd: 1'b0, wr: 1'b1, addr: 8'h40, data: m};
        expect_no_strobe("dual strobe", 6);

        for (int i = 0; i < 8; i++)
        begin
            dp_write_cycle("parked burst", addr_t'(8'h80 + i));
            addrs.push_back(addr_t'(8'h80 + i));
            if (i == 2)
            begin
                cpu_pkt = '{rd: 1'b1, wr: 1'b0, addr: 8'h40, data: '0};
            end
            if (i == 3)
            begin
                cpu_meta = '{rd: 1'b0, wr: 1'b1, addr: 8'h10, data: ~m};  // dropped
            end
        end
        dp_release();
        wait_result("parked rd", STB_RD_PKT);
        check_value("parked rd data", 128'(pkt_model[8'h40]), 128'(cpu_res.pkt_data));
        expect_no_strobe("ignored wr", 6);
        addrs.push_back(8'h40);
        addrs.push_back(8'h10);
        dp_read_check("ignored dp", addrs);
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////

    initial
    begin
        void'($urandom(34604));
        rstn       = 1'b0;
        dp_wr      = '0;
        dp_rd_addr = '0;
        cpu_pkt    = '0;
        cpu_meta   = '0;
        repeat (16) @(negedge clk);
        rstn = 1'b1;

        test_reset_state();
        test_dp_write_read();
        test_cpu_port_free();
        test_back_pressure();
        test_ignored_requests();

        repeat (2) @(negedge clk);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- tb.f
+incdir+hw
hw/pbuf_pkg.sv
hw/dual_port_ram.sv
hw/cpu_port_arbiter.sv
hw/cpu_response.sv
hw/pkt_buffer_top.sv
tests/pkt_buffer_props.sv
tests/pkt_buffer_tb.sv

//--- run.sh
#!/bin/sh
# compile and run the packet buffer testbench with verilator

cd "$(dirname "$0")" || exit 1

TOP=pkt_buffer_tb
OBJ_DIR=obj_dir
SIM="$OBJ_DIR/V$TOP"

if ! command -v verilator > /dev/null 2>&1
then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --assert \
    --top-module "$TOP" \
    --Mdir "$OBJ_DIR" \
    -f tb.f
status=$?
if [ $status -ne 0 ]
then
    echo "build failed with status $status"
    exit $status
fi

"$SIM"
status=$?
if [ $status -ne 0 ]
then
    echo "simulation ended with status $status"
    exit $status
fi

exit 0
